/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f sim.f --top-module PipeCoreTb -o PipeCoreTb

run: build
	./obj_dir/PipeCoreTb | tee sim.log
	@if grep -qF "*** TEST FAILED ***" sim.log; then exit 1; fi
	@grep -qF "*** TEST PASSED ***" sim.log

lint:
	verilator --lint-only --timing -f sim.f --top-module PipeCoreTb

clean:
	rm -rf obj_dir sim.log

/* sim.f */
source/PipeDefines.sv
source/PipeStageReg.sv
source/RegFile.sv
source/HazardDetect.sv
source/MulUnit.sv
source/PipeControl.sv
source/PipeCore.sv
verification/PipeCoreTb.sv

/* source/HazardDetect.sv */
// Read-after-write hazard detection
`timescale 1ns/1ps

module HazardDetect (
    input  logic                                 idValid,
    input  PipeDefines::instr_t                  idInstr,
    input  logic                                 exeValid,
    input  logic [PipeDefines::RegAddrWidth-1:0] exeRd,
    input  logic                                 mem1Valid,
    input  logic [PipeDefines::RegAddrWidth-1:0] mem1Rd,
    input  logic                                 mem2Valid,
    input  logic [PipeDefines::RegAddrWidth-1:0] mem2Rd,
    output logic                                 dhExe,
    output logic                                 dhMem1,
    output logic                                 dhMem2
);

    logic readsRt;

    // Every opcode writes rd, so a valid stage with rd != 0 is pending
    function automatic logic conflict(
        input logic                                 stageValid,
        input logic [PipeDefines::RegAddrWidth-1:0] stageRd,
        input logic [PipeDefines::RegAddrWidth-1:0] rs,
        input logic [PipeDefines::RegAddrWidth-1:0] rt,
        input logic                                 useRt
    );
        logic pending;
        pending = stageValid && (stageRd != '0);
        return pending && ((stageRd == rs) || (useRt && stageRd == rt));
    endfunction

    // Immediate forms only read rs
    assign readsRt = (idInstr.op == PipeDefines::OpAdd) ||
                     (idInstr.op == PipeDefines::OpMul);

    always_comb begin
        dhExe  = 1'b0;
        dhMem1 = 1'b0;
        dhMem2 = 1'b0;
        if (idValid) begin
            dhExe  = conflict(exeValid, exeRd, idInstr.rs, idInstr.rt, readsRt);
            dhMem1 = conflict(mem1Valid, mem1Rd, idInstr.rs, idInstr.rt, readsRt);
            dhMem2 = conflict(mem2Valid, mem2Rd, idInstr.rs, idInstr.rt, readsRt);
        end
    end

endmodule

/* source/MulUnit.sv */
// Iterative shift-add multiplier
`timescale 1ns/1ps

module MulUnit #(
    parameter int MulCycles = 8
) (
    input  logic                              clk,
    input  logic                              arstN,
    input  logic                              start,
    input  logic [PipeDefines::DataWidth-1:0] a,
    input  logic [PipeDefines::DataWidth-1:0] b,
    output logic                              busy,
    output logic [PipeDefines::DataWidth-1:0] product
);

    // Multiplier bits retired per cycle
    localparam int StepBits = (PipeDefines::DataWidth + MulCycles - 1) / MulCycles;
    localparam int CntWidth = (MulCycles > 1) ? $clog2(MulCycles) : 1;

    logic [PipeDefines::DataWidth-1:0] mcand;
    logic [PipeDefines::DataWidth-1:0] mplier;
    logic [PipeDefines::DataWidth-1:0] partial;
    logic [CntWidth-1:0]               stepCnt;

    // Partial products for the low StepBits of the multiplier
    always_comb begin
        partial = '0;
        for (int i = 0; i < StepBits; i++) begin
            if (mplier[i]) begin
                partial = partial + (mcand << i);
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busy    <= 1'b0;
            stepCnt <= '0;
        end else if (start) begin
            busy    <= 1'b1;
            stepCnt <= '0;
        end else if (busy) begin
            if (stepCnt == CntWidth'(MulCycles - 1)) begin
                busy <= 1'b0;  // Product final from next cycle
            end
            stepCnt <= stepCnt + CntWidth'(1);
        end
    end

    // Accumulate into product, low word only
    always_ff @(posedge clk) begin
        if (start) begin
            mcand   <= a;
            mplier  <= b;
            product <= '0;
        end else if (busy) begin
            product <= product + partial;
            mcand   <= mcand << StepBits;
            mplier  <= mplier >> StepBits;
        end
    end

endmodule

/* source/PipeControl.sv */
// Stall and flush controller
`timescale 1ns/1ps

module PipeControl (
    input  logic                    memStall,
    input  logic                    wbStall,
    input  logic                    mulBusy,
    input  logic                    dhExe,
    input  logic                    dhMem1,
    input  logic                    dhMem2,
    output PipeDefines::stageCtrl_t ctrl
);

    always_comb begin
        if (memStall || wbStall) begin
            // Back-pressure, freeze everything in place
            ctrl.idWr      = 1'b0;
            ctrl.exeWr     = 1'b0;
            ctrl.mem1Wr    = 1'b0;
            ctrl.mem2Wr    = 1'b0;
            ctrl.wbWr      = 1'b0;

            ctrl.idFlush   = 1'b0;
            ctrl.exeFlush  = 1'b0;
            ctrl.mem1Flush = 1'b0;
            ctrl.mem2Flush = 1'b0;
            ctrl.wbFlush   = 1'b0;
        end
        else if (mulBusy) begin
            // Multiply in EXE still iterating
            ctrl.idWr      = 1'b0;
            ctrl.exeWr     = 1'b0;
            ctrl.mem1Wr    = 1'b1;
            ctrl.mem2Wr    = 1'b1;
            ctrl.wbWr      = 1'b1;

            ctrl.idFlush   = 1'b0;
            ctrl.exeFlush  = 1'b0;
            ctrl.mem1Flush = 1'b1;  // Bubble behind the multiply
            ctrl.mem2Flush = 1'b0;
            ctrl.wbFlush   = 1'b0;
        end
        else if (dhMem2 || dhMem1 || dhExe) begin
            // All three hazard sources wait the same way for the writer to retire
            ctrl.idWr      = 1'b0;
            ctrl.exeWr     = 1'b1;
            ctrl.mem1Wr    = 1'b1;
            ctrl.mem2Wr    = 1'b1;
            ctrl.wbWr      = 1'b1;

            ctrl.idFlush   = 1'b0;
            ctrl.exeFlush  = 1'b1;  // Bubble into EXE
            ctrl.mem1Flush = 1'b0;
            ctrl.mem2Flush = 1'b0;
            ctrl.wbFlush   = 1'b0;
        end
        else begin
            ctrl.idWr      = 1'b1;
            ctrl.exeWr     = 1'b1;
            ctrl.mem1Wr    = 1'b1;
            ctrl.mem2Wr    = 1'b1;
            ctrl.wbWr      = 1'b1;

            ctrl.idFlush   = 1'b0;
            ctrl.exeFlush  = 1'b0;
            ctrl.mem1Flush = 1'b0;
            ctrl.mem2Flush = 1'b0;
            ctrl.wbFlush   = 1'b0;
        end
    end

endmodule

/* source/PipeCore.sv */
// Five-stage integer pipeline core
`timescale 1ns/1ps

module PipeCore #(
    parameter int MulCycles = 8
) (
    input  logic                              clk,
    input  logic                              arstN,
    input  logic                              instrValid,
    input  PipeDefines::instr_t               instr,
    output logic                              instrReady,
    output logic                              memReqValid,
    output logic [PipeDefines::DataWidth-1:0] memAddr,
    input  logic                              memReady,
    input  logic [PipeDefines::DataWidth-1:0] memRdata,
    output logic                              retireValid,
    output PipeDefines::wbPayload_t           retire,
    input  logic                              retireReady
);

    localparam int DataWidth = PipeDefines::DataWidth;
    localparam int ImmWidth  = PipeDefines::ImmWidth;

    PipeDefines::stageCtrl_t  ctrl;
    PipeDefines::instr_t      idInstr;
    PipeDefines::exePayload_t exeIn, exe;
    PipeDefines::memPayload_t mem1In, mem1, mem2In, mem2;
    PipeDefines::wbPayload_t  wbIn;

    logic                 idValid, exeValid, mem1Valid, mem2Valid;
    logic [DataWidth-1:0] rsData, rtData;
    logic [DataWidth-1:0] immExt, product;
    logic                 mulBusy, mulStart, mem1Load;
    logic                 dhExe, dhMem1, dhMem2;
    logic                 memStall, wbStall, commit, wbValid;

    assign instrReady = ctrl.idWr;

    PipeStageReg #(.PayloadT(PipeDefines::instr_t)) u_IdReg (
        .clk(clk), .arstN(arstN), .en(ctrl.idWr), .flush(ctrl.idFlush),
        .validIn(instrValid), .dataIn(instr), .validOut(idValid), .dataOut(idInstr)
    );

    RegFile u_RegFile (
        .clk(clk), .arstN(arstN),
        .rsAddr(idInstr.rs), .rtAddr(idInstr.rt), .rsData(rsData), .rtData(rtData),
        .wrEn(commit), .wrAddr(retire.rd), .wrData(retire.data)
    );

    HazardDetect u_HazardDetect (
        .idValid(idValid), .idInstr(idInstr),
        .exeValid(exeValid), .exeRd(exe.rd), .mem1Valid(mem1Valid), .mem1Rd(mem1.rd),
        .mem2Valid(mem2Valid), .mem2Rd(mem2.rd),
        .dhExe(dhExe), .dhMem1(dhMem1), .dhMem2(dhMem2)
    );

    // Decode, operands read straight from the register file
    always_comb begin
        exeIn.op  = idInstr.op;
        exeIn.rd  = idInstr.rd;
        exeIn.a   = rsData;
        exeIn.b   = rtData;
        exeIn.imm = idInstr.imm;
    end

    PipeStageReg #(.PayloadT(PipeDefines::exePayload_t)) u_ExeReg (
        .clk(clk), .arstN(arstN), .en(ctrl.exeWr), .flush(ctrl.exeFlush),
        .validIn(idValid), .dataIn(exeIn), .validOut(exeValid), .dataOut(exe)
    );

    // Multiply kicks off on the edge it enters EXE
    assign mulStart = ctrl.exeWr && !ctrl.exeFlush && idValid &&
                      (idInstr.op == PipeDefines::OpMul);

    MulUnit #(.MulCycles(MulCycles)) u_MulUnit (
        .clk(clk), .arstN(arstN), .start(mulStart), .a(rsData), .b(rtData),
        .busy(mulBusy), .product(product)
    );

    assign immExt = {{(DataWidth - ImmWidth){exe.imm[ImmWidth-1]}}, exe.imm};

    always_comb begin
        mem1In.op = exe.op;
        mem1In.rd = exe.rd;
        case (exe.op)
            PipeDefines::OpAdd: mem1In.data = exe.a + exe.b;
            PipeDefines::OpMul: mem1In.data = product;
            default:            mem1In.data = exe.a + immExt;  // Addi result or load address
        endcase
    end

    PipeStageReg #(.PayloadT(PipeDefines::memPayload_t)) u_Mem1Reg (
        .clk(clk), .arstN(arstN), .en(ctrl.mem1Wr), .flush(ctrl.mem1Flush),
        .validIn(exeValid), .dataIn(mem1In), .validOut(mem1Valid), .dataOut(mem1)
    );

    assign mem1Load = mem1Valid && (mem1.op == PipeDefines::OpLoad);
    assign memStall = mem1Load && !memReady;
    assign wbStall  = retireValid && !retireReady;
    // No request while retire holds the pipe, MEM2 could not take the data
    assign memReqValid = mem1Load && !wbStall;
    assign memAddr     = mem1.data;

    always_comb begin
        mem2In      = mem1;
        if (mem1.op == PipeDefines::OpLoad) begin
            mem2In.data = memRdata;
        end
    end

    PipeStageReg #(.PayloadT(PipeDefines::memPayload_t)) u_Mem2Reg (
        .clk(clk), .arstN(arstN), .en(ctrl.mem2Wr), .flush(ctrl.mem2Flush),
        .validIn(mem1Valid), .dataIn(mem2In), .validOut(mem2Valid), .dataOut(mem2)
    );

    always_comb begin
        wbIn.rd   = mem2.rd;
        wbIn.data = mem2.data;
    end

    PipeStageReg #(.PayloadT(PipeDefines::wbPayload_t)) u_WbReg (
        .clk(clk), .arstN(arstN), .en(ctrl.wbWr), .flush(ctrl.wbFlush),
        .validIn(mem2Valid), .dataIn(wbIn), .validOut(wbValid), .dataOut(retire)
    );

    assign retireValid = wbValid && !memStall;  // WB cannot advance during a memory stall
    assign commit = retireValid && retireReady;  // Register write on retire handshake

    PipeControl u_PipeControl (
        .memStall(memStall), .wbStall(wbStall), .mulBusy(mulBusy),
        .dhExe(dhExe), .dhMem1(dhMem1), .dhMem2(dhMem2), .ctrl(ctrl)
    );

endmodule

/* source/PipeDefines.sv */
// Pipeline shared definitions
package PipeDefines;

    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 3;  // Eight registers, r0 reads as zero
    localparam int ImmWidth     = 16;

    typedef enum logic [1:0] {
        OpAdd,   // rd = rs + rt
        OpAddi,  // rd = rs + sext(imm)
        OpLoad,  // rd = mem[rs + sext(imm)]
        OpMul    // rd = low word of rs * rt
    } opcode_t;

    // Instruction port format
    typedef struct packed {
        opcode_t                 op;
        logic [RegAddrWidth-1:0] rd;
        logic [RegAddrWidth-1:0] rs;
        logic [RegAddrWidth-1:0] rt;
        logic [ImmWidth-1:0]     imm;
    } instr_t;

    typedef struct packed {
        opcode_t                 op;
        logic [RegAddrWidth-1:0] rd;
        logic [DataWidth-1:0]    a;     // rs value
        logic [DataWidth-1:0]    b;     // rt value
        logic [ImmWidth-1:0]     imm;
    } exePayload_t;

    // Result for ALU ops, address for loads
    typedef struct packed {
        opcode_t                 op;
        logic [RegAddrWidth-1:0] rd;
        logic [DataWidth-1:0]    data;
    } memPayload_t;

    typedef struct packed {
        logic [RegAddrWidth-1:0] rd;
        logic [DataWidth-1:0]    data;
    } wbPayload_t;

    typedef struct packed {
        logic idWr;
        logic exeWr;
        logic mem1Wr;
        logic mem2Wr;
        logic wbWr;
        logic idFlush;
        logic exeFlush;
        logic mem1Flush;
        logic mem2Flush;
        logic wbFlush;
    } stageCtrl_t;

endpackage

/* source/PipeStageReg.sv */
// Pipeline stage register
`timescale 1ns/1ps

module PipeStageReg #(
    parameter type PayloadT = logic
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    en,
    input  logic    flush,
    input  logic    validIn,
    input  PayloadT dataIn,
    output logic    validOut,
    output PayloadT dataOut
);

    // Valid bit, a flush turns the load into a bubble
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validOut <= 1'b0;
        end else if (en) begin
            validOut <= validIn && !flush;
        end
    end

    // Payload only moves on a real load
    always_ff @(posedge clk) begin
        if (en && !flush) begin
            dataOut <= dataIn;
        end
    end

endmodule

/* source/RegFile.sv */
// Register file with write-through
`timescale 1ns/1ps

module RegFile (
    input  logic                                 clk,
    input  logic                                 arstN,
    input  logic [PipeDefines::RegAddrWidth-1:0] rsAddr,
    input  logic [PipeDefines::RegAddrWidth-1:0] rtAddr,
    output logic [PipeDefines::DataWidth-1:0]    rsData,
    output logic [PipeDefines::DataWidth-1:0]    rtData,
    input  logic                                 wrEn,
    input  logic [PipeDefines::RegAddrWidth-1:0] wrAddr,
    input  logic [PipeDefines::DataWidth-1:0]    wrData
);

    localparam int NumRegs = 2 ** PipeDefines::RegAddrWidth;

    logic [PipeDefines::DataWidth-1:0] regs [NumRegs];

    // Architectural state starts at zero
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // r0 first, then the value committing this cycle
    assign rsData = (rsAddr == '0) ? '0 :
                    (wrEn && wrAddr == rsAddr) ? wrData : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 :
                    (wrEn && wrAddr == rtAddr) ? wrData : regs[rtAddr];

endmodule

/* verification/PipeCoreTb.sv */
// Pipeline core testbench
`timescale 1ns/1ps

module PipeCoreTb;

    localparam int MulCycles     = 8;
    localparam int NumEntries    = 16;
    localparam int TimeoutCycles = NumEntries * (MulCycles + 12) + 50;

    logic                              clk;
    logic                              arstN;
    logic                              instrValid;
    PipeDefines::instr_t               instr;
    logic                              instrReady;
    logic                              memReqValid;
    logic [PipeDefines::DataWidth-1:0] memAddr;
    logic                              memReady;
    logic [PipeDefines::DataWidth-1:0] memRdata;
    logic                              retireValid;
    PipeDefines::wbPayload_t           retire;
    logic                              retireReady;

    PipeDefines::instr_t               tbl    [NumEntries];
    PipeDefines::wbPayload_t           expTbl [NumEntries];
    logic [PipeDefines::DataWidth-1:0] expAddr [$];
    int issueIdx, memIdx, retCount, cycles;

    PipeCore #(.MulCycles(MulCycles)) u_PipeCore (
        .clk(clk), .arstN(arstN), .instrValid(instrValid), .instr(instr),
        .instrReady(instrReady), .memReqValid(memReqValid), .memAddr(memAddr),
        .memReady(memReady), .memRdata(memRdata), .retireValid(retireValid),
        .retire(retire), .retireReady(retireReady)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Memory content rule shared by the model and the memory responder
    function automatic logic [31:0] memWord(input logic [31:0] addr);
        return addr * 32'd3 + 32'd1;
    endfunction

    function automatic PipeDefines::instr_t encode(
        input PipeDefines::opcode_t op, input int rd, input int rs, input int rt,
        input logic [15:0] imm
    );
        PipeDefines::instr_t i;
        i.op  = op;
        i.rd  = rd[2:0];
        i.rs  = rs[2:0];
        i.rt  = rt[2:0];
        i.imm = imm;
        return i;
    endfunction

    // Program covers hazard distances 1 to 3, loads and multiplies
    function automatic void buildTable();
        logic [31:0] arch [8];
        logic [31:0] sImm, val;
        tbl[0]  = encode(PipeDefines::OpAddi, 1, 0, 0, 16'd5);
        tbl[1]  = encode(PipeDefines::OpAddi, 2, 0, 0, 16'hFFFD);
        tbl[2]  = encode(PipeDefines::OpAdd,  3, 1, 2, 16'd0);   // Distances 1 and 2
        tbl[3]  = encode(PipeDefines::OpAdd,  4, 3, 1, 16'd0);
        tbl[4]  = encode(PipeDefines::OpAddi, 6, 0, 0, 16'd7);
        tbl[5]  = encode(PipeDefines::OpAdd,  5, 3, 6, 16'd0);   // r3 at distance 3
        tbl[6]  = encode(PipeDefines::OpAdd,  7, 4, 5, 16'd0);
        tbl[7]  = encode(PipeDefines::OpAddi, 1, 5, 0, 16'd2);   // r5 at distance 2
        tbl[8]  = encode(PipeDefines::OpLoad, 2, 1, 0, 16'd16);
        tbl[9]  = encode(PipeDefines::OpAdd,  3, 2, 1, 16'd0);   // Uses the load
        tbl[10] = encode(PipeDefines::OpLoad, 4, 0, 0, 16'd100);
        tbl[11] = encode(PipeDefines::OpMul,  5, 3, 4, 16'd0);
        tbl[12] = encode(PipeDefines::OpAdd,  6, 5, 1, 16'd0);   // Right after the multiply
        tbl[13] = encode(PipeDefines::OpMul,  7, 6, 2, 16'd0);
        tbl[14] = encode(PipeDefines::OpAddi, 0, 7, 0, 16'd1);   // rd 0 still retires
        tbl[15] = encode(PipeDefines::OpAdd,  1, 7, 0, 16'd0);
        for (int r = 0; r < 8; r++) begin
            arch[r] = '0;
        end
        for (int n = 0; n < NumEntries; n++) begin
            sImm = {{16{tbl[n].imm[15]}}, tbl[n].imm};
            case (tbl[n].op)
                PipeDefines::OpAdd:  val = arch[tbl[n].rs] + arch[tbl[n].rt];
                PipeDefines::OpAddi: val = arch[tbl[n].rs] + sImm;
                PipeDefines::OpLoad: begin
                    expAddr.push_back(arch[tbl[n].rs] + sImm);
                    val = memWord(arch[tbl[n].rs] + sImm);
                end
                default:             val = arch[tbl[n].rs] * arch[tbl[n].rt];
            endcase
            expTbl[n].rd   = tbl[n].rd;
            expTbl[n].data = val;
            if (tbl[n].rd != 0) begin
                arch[tbl[n].rd] = val;
            end
        end
    endfunction

    task automatic checkRetire(input PipeDefines::wbPayload_t got,
                               input PipeDefines::wbPayload_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: retire %0d got rd %0d data %h, expected rd %0d data %h",
                     $time, retCount, got.rd, got.data, exp.rd, exp.data);
            $display("*** TEST FAILED ***");
            $fatal(1, "Retire check failed");
        end
    endtask

    task automatic checkMemAddr(input logic [PipeDefines::DataWidth-1:0] got,
                                input logic [PipeDefines::DataWidth-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: load %0d memAddr %h, expected %h",
                     $time, memIdx, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "Memory address check failed");
        end
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "Control signal check failed");
        end
    endtask

    initial begin
        void'($urandom(44818));
        arstN       = 1'b0;
        instrValid  = 1'b0;
        instr       = '0;
        memReady    = 1'b0;
        memRdata    = '0;
        retireReady = 1'b0;
        issueIdx    = 0;
        memIdx      = 0;
        retCount    = 0;
        cycles      = 0;
        buildTable();
        repeat (3) @(posedge clk);
        #1 arstN = 1'b1;
        @(negedge clk);
        checkFlag(retireValid, 1'b0, "retireValid after reset");
        checkFlag(memReqValid, 1'b0, "memReqValid after reset");
        checkFlag(instrReady, 1'b1, "instrReady after reset");
        while (retCount < NumEntries) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TimeoutCycles) begin
                $display("Timeout after %0d cycles with %0d of %0d retired",
                         cycles, retCount, NumEntries);
                $display("*** TEST FAILED ***");
                $fatal(1, "Run did not complete");
            end
            instrValid  = (issueIdx < NumEntries);
            instr       = (issueIdx < NumEntries) ? tbl[issueIdx] : '0;
            memReady    = ($urandom % 4) != 0;
            retireReady = ($urandom % 4) != 0;
            memRdata    = memWord(memAddr);
            // Handshakes complete on the coming edge
            @(negedge clk);
            if (instrValid && instrReady) begin
                issueIdx++;
            end
            if (memReqValid && memReady) begin
                checkMemAddr(memAddr, expAddr[memIdx]);
                memIdx++;
            end
            if (retireValid && retireReady) begin
                checkRetire(retire, expTbl[retCount]);
                retCount++;
            end
        end
        @(posedge clk);
        #1 instrValid = 1'b0;
        repeat (5) begin
            @(negedge clk);
            checkFlag(retireValid, 1'b0, "retireValid after last entry");
        end
        if (memIdx == expAddr.size() && issueIdx == NumEntries) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("Load count %0d or issue count %0d is wrong", memIdx, issueIdx);
            $display("*** TEST FAILED ***");
            $fatal(1, "Final count check failed");
        end
    end

endmodule
